/* Makefile */
# Verilator build and run of the E100 core testbench

SIM       ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_e100_core
FILELIST  := e100_core.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* e100_core.f */
+incdir+rtl
rtl/e100_pkg.sv
rtl/e100_alu.sv
rtl/fetch_unit.sv
rtl/execute_unit.sv
rtl/e100_core.sv
tests/e100_checker.sv
tests/tb_e100_core.sv

/* rtl/e100_alu.sv */
// combinational ALU, shift right is logical
// shift amounts of word width or more give zero
module e100_alu (
    input  e100_pkg::alu_op_t operation,
    input  e100_pkg::word_t   operand_a,
    input  e100_pkg::word_t   operand_b,
    output e100_pkg::word_t   result,
    output logic              equal,
    output logic              less_than
);
    import e100_pkg::*;

    localparam int shift_bits = $clog2($bits(word_t));

    logic shift_overflow;

    // any bit above the shift field set means shift past the word
    assign shift_overflow = |operand_b[$bits(word_t)-1:shift_bits];

    always_comb begin
        case (operation)
            alu_add: result = operand_a + operand_b;
            alu_sub: result = operand_a - operand_b;
            alu_and: result = operand_a & operand_b;
            alu_or: result = operand_a | operand_b;
            alu_not: result = ~operand_a;
            alu_shift_left: begin
                result = shift_overflow ? '0 : operand_a << operand_b[shift_bits-1:0];
            end
            alu_shift_right: begin
                result = shift_overflow ? '0 : operand_a >> operand_b[shift_bits-1:0];
            end
            // pass, used by cp
            default: result = operand_a;
        endcase
    end

    assign equal = (operand_a == operand_b);
    // signed compare for blt
    assign less_than = ($signed(operand_a) < $signed(operand_b));

endmodule

/* rtl/e100_cfg.svh */
// word and address widths and opcode values of the E100 instruction set
// opcodes 3, 4, 11, 12 and above 15 are not executed by this core
`ifndef E100_CFG_SVH
`define E100_CFG_SVH

`define E100_WORD_WIDTH 32
// low bits of a word select one of 1024 memory words
`define E100_ADDR_WIDTH 10

`define E100_OP_HALT 32'd0
`define E100_OP_ADD  32'd1
`define E100_OP_SUB  32'd2
`define E100_OP_CP   32'd5
`define E100_OP_AND  32'd6
`define E100_OP_OR   32'd7
`define E100_OP_NOT  32'd8
`define E100_OP_SL   32'd9
`define E100_OP_SR   32'd10
`define E100_OP_BE   32'd13
`define E100_OP_BNE  32'd14
`define E100_OP_BLT  32'd15

`endif

/* rtl/e100_core.sv */
// multicycle E100 core, program and data memory sit outside
// read_data must follow memory_address combinationally
module e100_core (
    input  logic               clock,
    input  logic               reset,
    input  e100_pkg::word_t    read_data,
    output e100_pkg::address_t memory_address,
    output logic               memory_write,
    output e100_pkg::word_t    write_data,
    output logic               halted
);
    import e100_pkg::*;

    address_t fetch_address;
    address_t execute_address;
    logic instruction_ready;
    logic execute_done;
    logic branch_taken;
    opcode_t opcode;
    word_t arg1;
    word_t arg2;
    word_t arg3;

    fetch_unit u_fetch (
        .clock             (clock),
        .reset             (reset),
        .read_data         (read_data),
        .execute_done      (execute_done),
        .branch_taken      (branch_taken),
        .fetch_address     (fetch_address),
        .instruction_ready (instruction_ready),
        .opcode            (opcode),
        .arg1              (arg1),
        .arg2              (arg2),
        .arg3              (arg3)
    );

    execute_unit u_execute (
        .clock             (clock),
        .reset             (reset),
        .instruction_ready (instruction_ready),
        .opcode            (opcode),
        .arg1              (arg1),
        .arg2              (arg2),
        .arg3              (arg3),
        .read_data         (read_data),
        .execute_address   (execute_address),
        .memory_write      (memory_write),
        .write_data        (write_data),
        .execute_done      (execute_done),
        .branch_taken      (branch_taken),
        .halted            (halted)
    );

    // execute owns the memory port while an instruction is held
    assign memory_address = instruction_ready ? execute_address : fetch_address;

endmodule

/* rtl/e100_pkg.sv */
// shared types of the E100 core
// opcode_t lists only the executed opcodes, other values can still appear
`include "e100_cfg.svh"

package e100_pkg;

    typedef logic [`E100_WORD_WIDTH-1:0] word_t;
    typedef logic [`E100_ADDR_WIDTH-1:0] address_t;

    typedef enum logic [`E100_WORD_WIDTH-1:0] {
        op_halt = `E100_OP_HALT,
        op_add  = `E100_OP_ADD,
        op_sub  = `E100_OP_SUB,
        op_cp   = `E100_OP_CP,
        op_and  = `E100_OP_AND,
        op_or   = `E100_OP_OR,
        op_not  = `E100_OP_NOT,
        op_sl   = `E100_OP_SL,
        op_sr   = `E100_OP_SR,
        op_be   = `E100_OP_BE,
        op_bne  = `E100_OP_BNE,
        op_blt  = `E100_OP_BLT
    } opcode_t;

    // result selection in the ALU
    typedef enum logic [2:0] {
        alu_pass,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_not,
        alu_shift_left,
        alu_shift_right
    } alu_op_t;

endpackage

/* rtl/execute_unit.sv */
// executes one held instruction, then pulses execute_done
// opcode and args must stay stable while instruction_ready is high
module execute_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               instruction_ready,
    input  e100_pkg::opcode_t  opcode,
    input  e100_pkg::word_t    arg1,
    input  e100_pkg::word_t    arg2,
    input  e100_pkg::word_t    arg3,
    input  e100_pkg::word_t    read_data,
    output e100_pkg::address_t execute_address,
    output logic               memory_write,
    output e100_pkg::word_t    write_data,
    output logic               execute_done,
    output logic               branch_taken,
    output logic               halted
);
    import e100_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_read_a,
        st_addr_b,
        st_read_b,
        st_addr_w,
        st_write,
        st_decide,
        st_halt
    } state_t;

    state_t state;
    alu_op_t operation;
    logic two_operands;
    logic is_branch;
    logic executable;
    logic branch_condition;
    word_t op1;
    word_t op2;
    word_t alu_result;
    logic equal;
    logic less_than;

    // instruction class and ALU selection
    always_comb begin
        operation = alu_pass;
        two_operands = 1'b0;
        is_branch = 1'b0;
        executable = 1'b1;
        case (opcode)
            op_add: begin
                operation = alu_add;
                two_operands = 1'b1;
            end
            op_sub: begin
                operation = alu_sub;
                two_operands = 1'b1;
            end
            op_and: begin
                operation = alu_and;
                two_operands = 1'b1;
            end
            op_or: begin
                operation = alu_or;
                two_operands = 1'b1;
            end
            op_sl: begin
                operation = alu_shift_left;
                two_operands = 1'b1;
            end
            op_sr: begin
                operation = alu_shift_right;
                two_operands = 1'b1;
            end
            op_not: operation = alu_not;
            op_cp: operation = alu_pass;
            op_be, op_bne, op_blt: begin
                two_operands = 1'b1;
                is_branch = 1'b1;
            end
            // halt and unsupported opcodes
            default: executable = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            op_be: branch_condition = equal;
            op_bne: branch_condition = !equal;
            op_blt: branch_condition = less_than;
            default: branch_condition = 1'b0;
        endcase
    end

    e100_alu u_alu (
        .operation (operation),
        .operand_a (op1),
        .operand_b (op2),
        .result    (alu_result),
        .equal     (equal),
        .less_than (less_than)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            memory_write <= 1'b0;
            execute_done <= 1'b0;
            branch_taken <= 1'b0;
            halted <= 1'b0;
        end else begin
            execute_done <= 1'b0;
            branch_taken <= 1'b0;
            memory_write <= 1'b0;
            case (state)
                st_idle: begin
                    // instruction_ready is still high in the done cycle
                    if (instruction_ready && !execute_done) begin
                        if (opcode == op_halt) begin
                            halted <= 1'b1;
                            state <= st_halt;
                        end else if (executable) begin
                            state <= st_read_a;
                        end else begin
                            execute_done <= 1'b1;
                        end
                    end
                end
                st_read_a: state <= two_operands ? st_addr_b : st_addr_w;
                st_addr_b: state <= st_read_b;
                st_read_b: state <= is_branch ? st_decide : st_addr_w;
                st_addr_w: begin
                    memory_write <= 1'b1;
                    state <= st_write;
                end
                st_write: begin
                    execute_done <= 1'b1;
                    state <= st_idle;
                end
                st_decide: begin
                    execute_done <= 1'b1;
                    branch_taken <= branch_condition;
                    state <= st_idle;
                end
                // stays here until reset
                st_halt: state <= st_halt;
                default: state <= st_idle;
            endcase
        end
    end

    // address and operand registers
    always_ff @(posedge clock) begin
        case (state)
            st_idle: execute_address <= address_t'(arg2);
            st_read_a: op1 <= read_data;
            st_addr_b: execute_address <= address_t'(arg3);
            st_read_b: op2 <= read_data;
            st_addr_w: begin
                execute_address <= address_t'(arg1);
                write_data <= alu_result;
            end
            default: begin
            end
        endcase
    end

endmodule

/* rtl/fetch_unit.sv */
// fetches opcode, arg1, arg2 and arg3 from pc upward, 8 cycles per instruction
// memory answers one cycle after fetch_address is loaded
module fetch_unit (
    input  logic               clock,
    input  logic               reset,
    input  e100_pkg::word_t    read_data,
    input  logic               execute_done,
    input  logic               branch_taken,
    output e100_pkg::address_t fetch_address,
    output logic               instruction_ready,
    output e100_pkg::opcode_t  opcode,
    output e100_pkg::word_t    arg1,
    output e100_pkg::word_t    arg2,
    output e100_pkg::word_t    arg3
);
    import e100_pkg::*;

    address_t pc;
    // even steps load the address, odd steps capture the word
    logic [2:0] step;
    // instruction register, word 0 is the opcode
    word_t instruction [4];

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            step <= '0;
            instruction_ready <= 1'b0;
        end else if (instruction_ready) begin
            // hold the instruction until execute finishes
            if (execute_done) begin
                instruction_ready <= 1'b0;
                if (branch_taken) begin
                    pc <= address_t'(arg1);
                end
            end
        end else begin
            // wraps to zero after the last word
            step <= step + 3'd1;
            if (step[0]) begin
                pc <= pc + address_t'(1);
                if (step == 3'd7) begin
                    instruction_ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!instruction_ready) begin
            if (step[0]) begin
                instruction[step[2:1]] <= read_data;
            end else begin
                fetch_address <= pc;
            end
        end
    end

    // unknown opcode values pass through the cast unchanged
    assign opcode = opcode_t'(instruction[0]);
    assign arg1 = instruction[1];
    assign arg2 = instruction[2];
    assign arg3 = instruction[3];

endmodule

/* tests/e100_checker.sv */
// reference model and write scoreboard for the E100 core testbench
// the shadow image must be loaded before reset is released, the program starts at mem[0]
`include "e100_cfg.svh"

module e100_checker #(
    parameter int depth = 1024
) (
    input logic               clock,
    input logic               reset,
    input e100_pkg::address_t memory_address,
    input logic               memory_write,
    input e100_pkg::word_t    write_data,
    input logic               halted
);
    timeunit 1ns;
    timeprecision 1ps;
    import e100_pkg::*;

    localparam int step_limit = 2000;
    localparam int ref_halt = 0;
    localparam int ref_write = 1;
    localparam int ref_lost = 2;

    word_t shadow [depth];
    address_t ref_pc;
    logic reset_last = 1'b0;
    string test_name = "startup";
    int test_writes = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int total_errors = 0;

    // one instruction on the shadow memory, the caller applies the write
    function automatic void reference_step(
        input  address_t pc,
        output logic     stops,
        output logic     writes,
        output address_t target,
        output word_t    value,
        output address_t next_pc
    );
        word_t opcode;
        word_t arg1;
        word_t x;
        word_t y;
        opcode = shadow[pc];
        arg1 = shadow[address_t'(pc + 1)];
        x = shadow[address_t'(shadow[address_t'(pc + 2)])];
        y = shadow[address_t'(shadow[address_t'(pc + 3)])];
        stops = 1'b0;
        writes = 1'b1;
        target = address_t'(arg1);
        value = x;
        next_pc = address_t'(pc + 4);
        case (opcode)
            `E100_OP_HALT: begin
                stops = 1'b1;
                writes = 1'b0;
                next_pc = pc;
            end
            `E100_OP_ADD: value = x + y;
            `E100_OP_SUB: value = x - y;
            `E100_OP_AND: value = x & y;
            `E100_OP_OR: value = x | y;
            `E100_OP_NOT: value = ~x;
            `E100_OP_CP: value = x;
            `E100_OP_SL: value = (y > 32'd31) ? '0 : x << y;
            `E100_OP_SR: value = (y > 32'd31) ? '0 : x >> y;
            `E100_OP_BE, `E100_OP_BNE, `E100_OP_BLT: begin
                writes = 1'b0;
                if ((opcode == `E100_OP_BE && x == y) || (opcode == `E100_OP_BNE && x != y)
                        || (opcode == `E100_OP_BLT && $signed(x) < $signed(y))) begin
                    next_pc = address_t'(arg1);
                end
            end
            // skipped, as the core does
            default: writes = 1'b0;
        endcase
    endfunction

    // steps the reference to its next write or to halt
    task automatic run_reference(output int outcome, output address_t target,
                                 output word_t value);
        logic stops;
        logic writes;
        address_t next_pc;
        int steps;
        outcome = ref_lost;
        steps = 0;
        target = '0;
        value = '0;
        while (outcome == ref_lost && steps < step_limit) begin
            reference_step(ref_pc, stops, writes, target, value, next_pc);
            steps++;
            if (stops) begin
                outcome = ref_halt;
            end else begin
                ref_pc = next_pc;
                if (writes) begin
                    outcome = ref_write;
                end
            end
        end
    endtask

    task automatic load_word(input address_t address, input word_t value);
        shadow[address] = value;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        ref_pc = '0;
        test_writes = 0;
        test_errors = 0;
    endtask

    always @(posedge clock) begin
        int outcome;
        address_t expected_address;
        word_t expected_value;
        if (reset_last && (memory_write !== 1'b0 || halted !== 1'b0)) begin
            $display("error in test %s: memory_write or halted high during reset", test_name);
            test_errors++;
        end
        if (!reset && memory_write === 1'b1) begin
            run_reference(outcome, expected_address, expected_value);
            test_writes++;
            if (outcome == ref_halt) begin
                $display("error in test %s: write to mem[%0d] after the program reached halt",
                         test_name, memory_address);
                test_errors++;
            end else if (outcome == ref_lost) begin
                $display("error in test %s: reference found no write within %0d instructions",
                         test_name, step_limit);
                test_errors++;
            end else begin
                if (expected_address !== memory_address || expected_value !== write_data) begin
                    $display("mismatch in test %s: expected mem[%0d] = %h, actual mem[%0d] = %h",
                             test_name, expected_address, expected_value,
                             memory_address, write_data);
                    test_errors++;
                end
                shadow[expected_address] = expected_value;
            end
        end
        reset_last <= reset;
    end

    // called once the core has halted and stayed quiet
    task automatic finish_test();
        int outcome;
        address_t expected_address;
        word_t expected_value;
        run_reference(outcome, expected_address, expected_value);
        if (outcome == ref_write) begin
            $display("error in test %s: expected write of %h to mem[%0d] never happened",
                     test_name, expected_value, expected_address);
            test_errors++;
        end else if (outcome == ref_lost) begin
            $display("error in test %s: reference did not reach halt", test_name);
            test_errors++;
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: passed, %0d writes checked", test_name, test_writes);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", test_name, test_errors);
        end
    endtask

endmodule

/* tests/tb_e100_core.sv */
// program and data live in a 1024-word memory model
// operands come from an LFSR with a fixed seed, so every run is the same
`include "e100_cfg.svh"

module tb_e100_core;
    timeunit 1ns;
    timeprecision 1ps;
    import e100_pkg::*;

    localparam int memory_depth = 1 << `E100_ADDR_WIDTH;
    localparam int halt_timeout = 5000;
    localparam int test_count = 5;

    logic clock;
    logic reset;
    word_t read_data;
    address_t memory_address;
    logic memory_write;
    word_t write_data;
    logic halted;
    word_t memory [memory_depth];
    word_t lfsr_state;

    e100_core uut (
        .clock          (clock),
        .reset          (reset),
        .read_data      (read_data),
        .memory_address (memory_address),
        .memory_write   (memory_write),
        .write_data     (write_data),
        .halted         (halted)
    );

    e100_checker #(.depth(memory_depth)) check (
        .clock          (clock),
        .reset          (reset),
        .memory_address (memory_address),
        .memory_write   (memory_write),
        .write_data     (write_data),
        .halted         (halted)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // no unit captures read_data in a write cycle
    assign read_data = memory[memory_address];

    always @(posedge clock) begin
        if (memory_write === 1'b1) begin
            memory[memory_address] = write_data;
        end
    end

    // taps 32, 22, 2, 1
    function automatic word_t lfsr_next(input word_t state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic word_t random_bits(input int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic store(input int address, input word_t value);
        memory[address_t'(address)] = value;
        check.load_word(address_t'(address), value);
    endtask

    task automatic place_instruction(input int address, input word_t opcode,
                                     input int arg1, input int arg2, input int arg3);
        store(address, opcode);
        store(address + 1, word_t'(arg1));
        store(address + 2, word_t'(arg2));
        store(address + 3, word_t'(arg3));
    endtask

    task automatic begin_test(input string name);
        @(negedge clock);
        reset = 1'b1;
        check.start_test(name);
        for (int i = 0; i < memory_depth; i++) begin
            store(i, word_t'(32'h5a00_0000 + i));
        end
    endtask

    task automatic wait_for_halt(output logic seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < halt_timeout) begin
            @(negedge clock);
            seen = (halted === 1'b1);
            cycles++;
        end
    endtask

    task automatic run_to_halt(input string name);
        logic seen;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        wait_for_halt(seen);
        if (!seen) begin
            $display("timeout in test %s: halted did not rise in %0d cycles", name, halt_timeout);
        end else begin
            // no write may follow the halt
            repeat (50) @(negedge clock);
            check.finish_test();
        end
    endtask

    // taken path writes 32'h7a4e, fall-through writes 32'h0a11, both to mem[700 + index]
    task automatic place_branch_case(input int index, input word_t opcode,
                                     input word_t left, input word_t right);
        int base;
        base = 16 * index;
        store(540 + 2 * index, left);
        store(541 + 2 * index, right);
        place_instruction(base, opcode, base + 12, 540 + 2 * index, 541 + 2 * index);
        place_instruction(base + 4, `E100_OP_CP, 700 + index, 530, 0);
        place_instruction(base + 8, `E100_OP_BE, base + 16, 531, 531);
        place_instruction(base + 12, `E100_OP_CP, 700 + index, 532, 0);
    endtask

    task automatic build_branch_program();
        word_t value;
        word_t negative;
        word_t positive;
        value = random_bits(32);
        negative = random_bits(32) | 32'h8000_0000;
        positive = random_bits(32) & 32'h7fff_ffff;
        store(530, 32'h0000_0a11);
        store(531, random_bits(32));
        store(532, 32'h0000_7a4e);
        place_branch_case(0, `E100_OP_BE, value, value);
        place_branch_case(1, `E100_OP_BE, value, value ^ 32'h1);
        place_branch_case(2, `E100_OP_BNE, value, value ^ 32'h8000_0000);
        place_branch_case(3, `E100_OP_BNE, value, value);
        place_branch_case(4, `E100_OP_BLT, negative, positive);
        place_branch_case(5, `E100_OP_BLT, positive, negative);
        place_instruction(96, `E100_OP_HALT, 0, 0, 0);
    endtask

    initial begin
        lfsr_state = 32'h6789;
        reset = 1'b1;

        begin_test("alu_ops");
        for (int i = 0; i < 8; i++) begin
            store(512 + i, random_bits(32));
        end
        store(520, random_bits(5));
        store(521, random_bits(5));
        // bit 5 set, so the shift reaches past the word width
        store(522, random_bits(5) | 32'h20);
        place_instruction(0, `E100_OP_ADD, 600, 512, 513);
        place_instruction(4, `E100_OP_SUB, 601, 514, 515);
        place_instruction(8, `E100_OP_AND, 602, 516, 517);
        place_instruction(12, `E100_OP_OR, 603, 518, 519);
        place_instruction(16, `E100_OP_NOT, 604, 512, 0);
        place_instruction(20, `E100_OP_SL, 605, 513, 520);
        place_instruction(24, `E100_OP_SR, 606, 514, 521);
        place_instruction(28, `E100_OP_SL, 607, 515, 522);
        place_instruction(32, `E100_OP_SR, 608, 600, 522);
        place_instruction(36, `E100_OP_ADD, 609, 600, 601);
        place_instruction(40, `E100_OP_HALT, 0, 0, 0);
        run_to_halt("alu_ops");

        begin_test("copy");
        store(512, random_bits(32));
        place_instruction(0, `E100_OP_CP, 610, 512, 0);
        place_instruction(4, `E100_OP_CP, 611, 610, 0);
        // source read again after the copy
        place_instruction(8, `E100_OP_CP, 612, 512, 0);
        place_instruction(12, `E100_OP_HALT, 0, 0, 0);
        run_to_halt("copy");

        begin_test("branches");
        build_branch_program();
        run_to_halt("branches");

        begin_test("halt");
        store(512, random_bits(32));
        store(513, random_bits(32));
        place_instruction(0, `E100_OP_ADD, 600, 512, 513);
        place_instruction(4, `E100_OP_HALT, 0, 0, 0);
        place_instruction(8, `E100_OP_ADD, 601, 512, 513);
        run_to_halt("halt");

        begin_test("reset_skip");
        store(512, random_bits(32));
        store(513, random_bits(32));
        place_instruction(0, 32'd20, 600, 512, 513);
        place_instruction(4, 32'd3, 600, 512, 513);
        place_instruction(8, 32'd12, 600, 512, 513);
        place_instruction(12, `E100_OP_SUB, 601, 512, 513);
        place_instruction(16, 32'd20, 601, 512, 513);
        place_instruction(20, `E100_OP_OR, 602, 512, 513);
        place_instruction(24, `E100_OP_HALT, 0, 0, 0);
        run_to_halt("reset_skip");

        $display("tests run: %0d, failed: %0d, errors: %0d",
                 check.tests_run, check.tests_failed, check.total_errors);
        if (check.tests_failed == 0 && check.tests_run == test_count) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
